/* include/hsi_macros.svh */
`ifndef HSI_MACROS_SVH
`define HSI_MACROS_SVH

// ====================
// bit timing
// ====================
`define HSI_BIT_DIV 8
`define HSI_OVS 4
`define HSI_RX_DIV (`HSI_BIT_DIV / `HSI_OVS)

// ====================
// frame layout
// ====================
`define HSI_DATA_BITS 8
`define HSI_FRAME_BITS (`HSI_DATA_BITS + 3)

// ====================
// supervisor limits
// ====================
`define HSI_REPLY_TIMEOUT 24
`define HSI_MAX_RETRIES 2

`endif

/* src/hsi_pkg.sv */
`default_nettype none

package hsi_pkg;

	// receive error flags reported at frame end.
	typedef struct packed {
		logic parity_err;
		logic stop_err;
		logic start_err;
	} rx_err_t;

	// line pair selector.
	typedef enum logic {
		LINE_1 = 1'b0,
		LINE_2 = 1'b1
	} line_t;

endpackage

`default_nettype wire

/* src/hsi_clk_en_gen.sv */
`default_nettype none

`include "hsi_macros.svh"

module hsi_clk_en_gen (
	input wire clk,
	input wire n_rst,
	output logic tx_clk_en,
	output logic rx_clk_en
);

	localparam int cnt_w = $clog2(`HSI_BIT_DIV);
	localparam int rx_div = `HSI_RX_DIV;

	logic [cnt_w-1:0] div_cnt;

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1; // wraps at bit period.
	end

	// both enables share one counter, so samples stay in phase.
	assign tx_clk_en = (div_cnt == cnt_w'(`HSI_BIT_DIV - 1));
	assign rx_clk_en = ((div_cnt % rx_div) == (rx_div - 1));

endmodule

`default_nettype wire

/* src/hsi_tx_ctrl.sv */
`default_nettype none

`include "hsi_macros.svh"

module hsi_tx_ctrl (
	input wire clk,
	input wire n_rst,
	input wire tx_clk_en,
	input wire cmd_start,
	input wire [`HSI_DATA_BITS-1:0] cmd_d,
	output logic tx_bit,
	output logic tx_busy,
	output logic tx_done
);

	localparam int frame_bits = `HSI_FRAME_BITS;
	localparam int cnt_w = $clog2(frame_bits + 1);
	localparam logic [cnt_w-1:0] last_cnt = cnt_w'(frame_bits);

	logic [frame_bits-1:0] frame_sr;
	logic [cnt_w-1:0] bit_cnt;
	logic accept;
	logic shift_en;

	assign accept = cmd_start && !tx_busy; // strobes while busy are dropped.
	assign shift_en = tx_busy && tx_clk_en;

	// ====================
	// frame shift register
	// ====================
	always_ff @(posedge clk)
	begin
		if (accept)
			frame_sr <= {1'b1, ~^cmd_d, cmd_d, 1'b0}; // stop, odd parity, data, start.
		else if (shift_en)
			frame_sr <= {1'b1, frame_sr[frame_bits-1:1]};
	end

	// ====================
	// control
	// ====================
	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			tx_busy <= 1'b0;
			tx_done <= 1'b0;
			tx_bit <= 1'b1;
			bit_cnt <= '0;
		end
		else
		begin
			tx_done <= 1'b0;
			if (accept)
			begin
				tx_busy <= 1'b1;
				bit_cnt <= '0;
			end
			else if (shift_en)
			begin
				if (bit_cnt == last_cnt)
				begin
					// stop bit has run its full period.
					tx_busy <= 1'b0;
					tx_done <= 1'b1;
					tx_bit <= 1'b1;
				end
				else
				begin
					tx_bit <= frame_sr[0];
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* src/hsi_rx_ctrl.sv */
`default_nettype none

`include "hsi_macros.svh"

module hsi_rx_ctrl
	import hsi_pkg::*;
(
	input wire clk,
	input wire n_rst,
	input wire rx_clk_en,
	input wire line_t active_line,
	input wire dat1,
	input wire dat2,
	output logic [`HSI_DATA_BITS-1:0] q,
	output logic q_rdy,
	output rx_err_t rx_errs,
	output logic rx_frame_end,
	output logic rx_start_bit
);

	localparam int ovs_w = $clog2(`HSI_OVS);
	localparam int idx_w = $clog2(`HSI_FRAME_BITS);
	localparam logic [ovs_w-1:0] half_bit = ovs_w'(`HSI_OVS / 2 - 1);
	localparam logic [ovs_w-1:0] full_bit = ovs_w'(`HSI_OVS - 1);
	localparam logic [idx_w-1:0] last_idx = idx_w'(`HSI_FRAME_BITS - 1);
	localparam logic [idx_w-1:0] data_idx = idx_w'(`HSI_DATA_BITS);

	logic [1:0] sync_r;
	logic smp;
	logic last_s;
	logic busy;
	logic [ovs_w-1:0] ovs_cnt;
	logic [idx_w-1:0] bit_idx;
	logic [`HSI_DATA_BITS-1:0] data_sr;
	logic par_acc;
	logic start_bad;
	logic take;

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
			sync_r <= '1;
		else
			sync_r <= {sync_r[0], (active_line == LINE_1) ? dat1 : dat2};
	end

	assign smp = sync_r[1];
	assign take = rx_clk_en && busy && (ovs_cnt == '0); // mid-bit sample.

	// ====================
	// frame control
	// ====================
	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			last_s <= 1'b1;
			busy <= 1'b0;
			ovs_cnt <= '0;
			bit_idx <= '0;
			q_rdy <= 1'b0;
			rx_frame_end <= 1'b0;
			rx_start_bit <= 1'b0;
			rx_errs <= '0;
		end
		else
		begin
			q_rdy <= 1'b0;
			rx_frame_end <= 1'b0;
			rx_start_bit <= 1'b0;
			if (rx_clk_en)
			begin
				last_s <= smp;
				if (!busy)
				begin
					if (last_s && !smp)
					begin
						busy <= 1'b1;
						ovs_cnt <= half_bit;
						bit_idx <= '0;
						rx_start_bit <= 1'b1;
					end
				end
				else if (ovs_cnt != '0)
					ovs_cnt <= ovs_cnt - 1'b1;
				else
				begin
					ovs_cnt <= full_bit;
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == last_idx)
					begin
						busy <= 1'b0;
						q_rdy <= 1'b1;
						rx_frame_end <= 1'b1;
						rx_errs.parity_err <= ~par_acc;
						rx_errs.stop_err <= ~smp;
						rx_errs.start_err <= start_bad;
					end
				end
			end
		end
	end

	// ====================
	// data path
	// ====================
	always_ff @(posedge clk)
	begin
		if (take)
		begin
			if (bit_idx == '0)
			begin
				start_bad <= smp; // start bit gone high.
				par_acc <= 1'b0;
			end
			else if (bit_idx == last_idx)
				q <= data_sr;
			else
			begin
				par_acc <= par_acc ^ smp; // data and parity bits.
				if (bit_idx <= data_idx)
					data_sr <= {smp, data_sr[`HSI_DATA_BITS-1:1]};
			end
		end
	end

endmodule

`default_nettype wire

/* src/hsi_emergency_ctrl.sv */
`default_nettype none

`include "hsi_macros.svh"

module hsi_emergency_ctrl
	import hsi_pkg::*;
(
	input wire clk,
	input wire n_rst,
	input wire tx_clk_en,
	input wire tx_done,
	input wire rx_start_bit,
	input wire rx_frame_end,
	input wire rx_err_t rx_errs,
	output logic repeat_req,
	output logic switch_line
);

	localparam int tmr_w = $clog2(`HSI_REPLY_TIMEOUT + 1);
	localparam int rty_w = $clog2(`HSI_MAX_RETRIES + 1);

	logic waiting;
	logic [tmr_w-1:0] timer;
	logic [rty_w-1:0] retry_cnt;
	logic timed_out;
	logic reply_bad;
	logic reply_good;
	logic fail;

	assign timed_out = waiting && tx_clk_en && (timer == tmr_w'(`HSI_REPLY_TIMEOUT - 1));
	assign reply_bad = rx_frame_end && (|rx_errs);
	assign reply_good = rx_frame_end && !(|rx_errs);
	assign fail = timed_out || reply_bad;

	// ====================
	// reply window
	// ====================
	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			waiting <= 1'b0;
			timer <= '0;
		end
		else if (tx_done)
		begin
			waiting <= 1'b1;
			timer <= '0;
		end
		else if (rx_start_bit || timed_out)
			waiting <= 1'b0;
		else if (waiting && tx_clk_en)
			timer <= timer + 1'b1; // counts bit periods.
	end

	// ====================
	// retry accounting
	// ====================
	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			repeat_req <= 1'b0;
			switch_line <= 1'b0;
			retry_cnt <= '0;
		end
		else
		begin
			repeat_req <= fail;
			switch_line <= 1'b0;
			if (fail)
			begin
				if (retry_cnt == rty_w'(`HSI_MAX_RETRIES - 1))
				begin
					switch_line <= 1'b1; // give up on this pair.
					retry_cnt <= '0;
				end
				else
					retry_cnt <= retry_cnt + 1'b1;
			end
			else if (reply_good)
				retry_cnt <= '0;
		end
	end

endmodule

`default_nettype wire

/* src/hsi_line_select.sv */
`default_nettype none

module hsi_line_select
	import hsi_pkg::*;
(
	input wire clk,
	input wire n_rst,
	input wire base_com,
	input wire switch_line,
	input wire tx_bit,
	output logic com1,
	output logic com2,
	output line_t active_line
);

	logic flip;

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
			flip <= 1'b0;
		else if (switch_line)
			flip <= ~flip;
	end

	assign active_line = line_t'(base_com ^ flip);

	// inactive line idles high.
	assign com1 = (active_line == LINE_1) ? tx_bit : 1'b1;
	assign com2 = (active_line == LINE_2) ? tx_bit : 1'b1;

endmodule

`default_nettype wire

/* src/hsi_master.sv */
`default_nettype none

`include "hsi_macros.svh"

module hsi_master
	import hsi_pkg::*;
(
	input wire clk,
	input wire n_rst,
	input wire cmd_start,
	input wire [`HSI_DATA_BITS-1:0] cmd_d,
	input wire base_com,
	input wire dat1,
	input wire dat2,
	output logic tx_busy,
	output logic com1,
	output logic com2,
	output logic [`HSI_DATA_BITS-1:0] q,
	output logic q_rdy,
	output rx_err_t rx_errs,
	output logic rx_frame_end,
	output logic repeat_req,
	output line_t active_line
);

	logic tx_clk_en;
	logic rx_clk_en;
	logic tx_bit;
	logic tx_done;
	logic rx_start_bit;
	logic switch_line;

	hsi_clk_en_gen u_clk_en_gen (
		.clk(clk),
		.n_rst(n_rst),
		.tx_clk_en(tx_clk_en),
		.rx_clk_en(rx_clk_en)
	);

	hsi_tx_ctrl u_tx_ctrl (
		.clk(clk),
		.n_rst(n_rst),
		.tx_clk_en(tx_clk_en),
		.cmd_start(cmd_start),
		.cmd_d(cmd_d),
		.tx_bit(tx_bit),
		.tx_busy(tx_busy),
		.tx_done(tx_done)
	);

	hsi_rx_ctrl u_rx_ctrl (
		.clk(clk),
		.n_rst(n_rst),
		.rx_clk_en(rx_clk_en),
		.active_line(active_line),
		.dat1(dat1),
		.dat2(dat2),
		.q(q),
		.q_rdy(q_rdy),
		.rx_errs(rx_errs),
		.rx_frame_end(rx_frame_end),
		.rx_start_bit(rx_start_bit)
	);

	hsi_emergency_ctrl u_emergency_ctrl (
		.clk(clk),
		.n_rst(n_rst),
		.tx_clk_en(tx_clk_en),
		.tx_done(tx_done),
		.rx_start_bit(rx_start_bit),
		.rx_frame_end(rx_frame_end),
		.rx_errs(rx_errs),
		.repeat_req(repeat_req),
		.switch_line(switch_line)
	);

	hsi_line_select u_line_select (
		.clk(clk),
		.n_rst(n_rst),
		.base_com(base_com),
		.switch_line(switch_line),
		.tx_bit(tx_bit),
		.com1(com1),
		.com2(com2),
		.active_line(active_line)
	);

endmodule

`default_nettype wire

/* tb/hsi_master_sva.sv */
`default_nettype none

module hsi_master_sva
	import hsi_pkg::*;
(
	input wire clk,
	input wire n_rst,
	input wire com1,
	input wire com2,
	input wire tx_busy,
	input wire q_rdy,
	input wire rx_frame_end,
	input wire repeat_req,
	input wire line_t active_line
);

	// ====================
	// line idle
	// ====================
	inactive_idle: assert property (@(posedge clk) disable iff (!n_rst)
		((active_line == LINE_1) ? com2 : com1))
		else $error("inactive com line driven low");

	idle_high: assert property (@(posedge clk) disable iff (!n_rst)
		!tx_busy |-> (com1 && com2))
		else $error("com line low while transmitter idle");

	// ====================
	// pulses
	// ====================
	rdy_with_end: assert property (@(posedge clk) disable iff (!n_rst)
		q_rdy == rx_frame_end)
		else $error("q_rdy and rx_frame_end out of step");

	repeat_pulse: assert property (@(posedge clk) disable iff (!n_rst)
		repeat_req |=> !repeat_req)
		else $error("repeat_req held longer than one cycle");

endmodule

bind hsi_master hsi_master_sva u_hsi_master_sva (
	.clk(clk),
	.n_rst(n_rst),
	.com1(com1),
	.com2(com2),
	.tx_busy(tx_busy),
	.q_rdy(q_rdy),
	.rx_frame_end(rx_frame_end),
	.repeat_req(repeat_req),
	.active_line(active_line)
);

`default_nettype wire

/* tb/hsi_master_tb.sv */
`default_nettype none

`include "hsi_macros.svh"

module hsi_master_tb
	import hsi_pkg::*;
();

	localparam int data_bits = `HSI_DATA_BITS;
	localparam int frame_bits = `HSI_FRAME_BITS;
	localparam int bit_div = `HSI_BIT_DIV;
	localparam int gap_bits = 3;
	localparam int n_exchanges = 14;
	localparam int exchange_cycles = (`HSI_REPLY_TIMEOUT + 30) * bit_div;
	localparam int watchdog_time = n_exchanges * exchange_cycles * 4;
	localparam int fault_none = 0;
	localparam int fault_parity = 1;
	localparam int fault_stop = 2;
	localparam int fault_silent = 3;
	localparam int sel_cmd = 0;
	localparam int sel_rdy = 1;
	localparam int sel_rep = 2;

	logic clk;
	logic n_rst;
	logic cmd_start;
	logic [data_bits-1:0] cmd_d;
	logic base_com;
	logic dat1;
	logic dat2;
	logic tx_busy;
	logic com1;
	logic com2;
	logic [data_bits-1:0] q;
	logic q_rdy;
	rx_err_t rx_errs;
	logic rx_frame_end;
	logic repeat_req;
	line_t active_line;

	logic [data_bits-1:0] slv_reply; // reply byte for the slave model.
	int slv_fault;
	logic slv_busy;
	logic [frame_bits-1:0] dec_frame; // command as seen on the wire.
	line_t dec_line;
	logic other_low;
	logic [data_bits+2:0] exp_q[$];
	int n_cmd = 0;
	int n_rdy = 0;
	int n_rep = 0;
	int n_check_err = 0;
	int n_other_err = 0;

	hsi_master u_hsi_master (
		.clk(clk),
		.n_rst(n_rst),
		.cmd_start(cmd_start),
		.cmd_d(cmd_d),
		.base_com(base_com),
		.dat1(dat1),
		.dat2(dat2),
		.tx_busy(tx_busy),
		.com1(com1),
		.com2(com2),
		.q(q),
		.q_rdy(q_rdy),
		.rx_errs(rx_errs),
		.rx_frame_end(rx_frame_end),
		.repeat_req(repeat_req),
		.active_line(active_line)
	);

	// ====================
	// frame rule
	// ====================
	function automatic logic [frame_bits-1:0] wire_frame(input logic [data_bits-1:0] data,
		input int fault);
		logic par;
		logic stp;
		par = ($countones(data) % 2 == 0); // ones in data plus parity come out odd.
		stp = 1'b1;
		if (fault == fault_parity)
			par = ~par;
		if (fault == fault_stop)
			stp = 1'b0;
		return {stp, par, data, 1'b0}; // bit 0 goes out first.
	endfunction

	function automatic logic [data_bits+2:0] frame_expect(input logic [data_bits-1:0] data,
		input int fault);
		rx_err_t errs;
		errs = '0;
		errs.parity_err = (fault == fault_parity);
		errs.stop_err = (fault == fault_stop);
		return {errs, data};
	endfunction

	function automatic int count_of(input int which);
		case (which)
			sel_cmd: return n_cmd;
			sel_rdy: return n_rdy;
			default: return n_rep;
		endcase
	endfunction

	task automatic await_count(input int which, input int base, input string what);
		int cycles;
		cycles = 0;
		while (count_of(which) == base && cycles < exchange_cycles)
		begin
			@(posedge clk);
			cycles++;
		end
		if (count_of(which) == base)
		begin
			$display("%0t: no %s arrived within the exchange window", $time, what);
			n_other_err++;
		end
	endtask

	task automatic apply_reset(input logic base);
		@(posedge clk);
		n_rst <= 1'b0;
		base_com <= base;
		repeat (5) @(posedge clk);
		n_rst <= 1'b1;
		@(posedge clk);
		if (active_line !== line_t'(base))
		begin
			$display("CHECK FAILED %0t: active line %b after reset, expected %b",
				$time, active_line, base);
			n_check_err++;
		end
	endtask

	task automatic run_exchange(input int fault, input line_t exp_line);
		logic [31:0] rnd;
		logic [data_bits-1:0] cmd;
		int rdy0;
		int rep0;
		int cmd0;
		rnd = $urandom;
		cmd = rnd[data_bits-1:0];
		rnd = $urandom;
		slv_reply = rnd[data_bits-1:0];
		slv_fault = fault;
		if (fault != fault_silent)
			exp_q.push_back(frame_expect(slv_reply, fault));
		rdy0 = n_rdy;
		rep0 = n_rep;
		cmd0 = n_cmd;
		while (tx_busy)
			@(posedge clk);
		@(posedge clk);
		cmd_start <= 1'b1;
		cmd_d <= cmd;
		@(posedge clk);
		cmd_start <= 1'b0;
		@(posedge clk);
		if (tx_busy !== 1'b1)
		begin
			$display("CHECK FAILED %0t: tx_busy %b after command strobe, expected 1",
				$time, tx_busy);
			n_check_err++;
		end
		await_count(sel_cmd, cmd0, "command frame");
		if (dec_frame !== wire_frame(cmd, fault_none))
		begin
			$display("CHECK FAILED %0t: command frame %b, expected %b",
				$time, dec_frame, wire_frame(cmd, fault_none));
			n_check_err++;
		end
		if (dec_line !== exp_line)
		begin
			$display("CHECK FAILED %0t: command on line %b, expected %b",
				$time, dec_line, exp_line);
			n_check_err++;
		end
		if (other_low)
		begin
			$display("CHECK FAILED %0t: inactive com line left idle level", $time);
			n_check_err++;
		end
		if (fault == fault_none)
			await_count(sel_rdy, rdy0, "reply");
		else
			await_count(sel_rep, rep0, "repeat request");
		while (slv_busy)
			@(posedge clk);
		repeat (4) @(posedge clk);
		if (n_rep != rep0 + ((fault == fault_none) ? 0 : 1))
		begin
			$display("%0t: saw %0d repeat requests in this exchange, expected %0d",
				$time, n_rep - rep0, (fault == fault_none) ? 0 : 1);
			n_other_err++;
		end
		if (n_rdy != rdy0 + ((fault == fault_silent) ? 0 : 1))
		begin
			$display("%0t: saw %0d replies in this exchange, expected %0d",
				$time, n_rdy - rdy0, (fault == fault_silent) ? 0 : 1);
			n_other_err++;
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	// ====================
	// slave model
	// ====================
	initial
	begin : slave_model
		logic on_com2;
		logic [frame_bits-1:0] reply;
		dat1 = 1'b1;
		dat2 = 1'b1;
		slv_busy = 1'b0;
		forever
		begin
			@(posedge clk);
			if (n_rst === 1'b1 && (com1 === 1'b0 || com2 === 1'b0))
			begin
				slv_busy = 1'b1;
				on_com2 = (com2 === 1'b0);
				other_low = 1'b0;
				repeat (bit_div / 2 - 1) @(posedge clk); // to mid start bit.
				for (int i = 0; i < frame_bits; i++)
				begin
					dec_frame[i] = on_com2 ? com2 : com1;
					if ((on_com2 ? com1 : com2) !== 1'b1)
						other_low = 1'b1;
					if (i < frame_bits - 1)
						repeat (bit_div) @(posedge clk);
				end
				dec_line = on_com2 ? LINE_2 : LINE_1;
				n_cmd++;
				if (slv_fault != fault_silent)
				begin
					reply = wire_frame(slv_reply, slv_fault);
					repeat (gap_bits * bit_div) @(posedge clk);
					for (int i = 0; i < frame_bits; i++)
					begin
						if (on_com2)
							dat2 <= reply[i];
						else
							dat1 <= reply[i];
						repeat (bit_div) @(posedge clk);
					end
					dat1 <= 1'b1;
					dat2 <= 1'b1;
				end
				slv_busy = 1'b0;
			end
		end
	end

	// ====================
	// compare
	// ====================
	initial
	begin : compare
		logic [data_bits+2:0] exp;
		forever
		begin
			@(posedge clk);
			if (repeat_req === 1'b1)
				n_rep++;
			if (q_rdy === 1'b1)
			begin
				n_rdy++;
				if (exp_q.size() == 0)
				begin
					$display("%0t: reply reported while none was expected", $time);
					n_other_err++;
				end
				else
				begin
					exp = exp_q.pop_front();
					if (q !== exp[data_bits-1:0])
					begin
						$display("CHECK FAILED %0t: q %h, expected %h",
							$time, q, exp[data_bits-1:0]);
						n_check_err++;
					end
					if (rx_errs !== exp[data_bits+2:data_bits])
					begin
						$display("CHECK FAILED %0t: rx_errs %b, expected %b",
							$time, rx_errs, exp[data_bits+2:data_bits]);
						n_check_err++;
					end
				end
			end
		end
	end

	initial
	begin
		#(watchdog_time);
		$display("%0t: watchdog expired before the last exchange finished", $time);
		$display("test failed");
		$finish;
	end

	initial
	begin
		void'($urandom(78899));
		n_rst = 1'b0;
		cmd_start = 1'b0;
		cmd_d = '0;
		base_com = 1'b0;
		apply_reset(1'b0);
		repeat (3) run_exchange(fault_none, LINE_1);
		run_exchange(fault_parity, LINE_1); // single failures clear the count.
		run_exchange(fault_none, LINE_1);
		run_exchange(fault_stop, LINE_1);
		run_exchange(fault_none, LINE_1);
		run_exchange(fault_silent, LINE_1);
		run_exchange(fault_none, LINE_1);
		run_exchange(fault_parity, LINE_1); // two in a row force a switch.
		run_exchange(fault_silent, LINE_1);
		if (active_line !== LINE_2)
		begin
			$display("CHECK FAILED %0t: active line %b after retries, expected %b",
				$time, active_line, LINE_2);
			n_check_err++;
		end
		run_exchange(fault_none, LINE_2);
		apply_reset(1'b1);
		repeat (2) run_exchange(fault_none, LINE_2);
		if (exp_q.size() != 0)
		begin
			$display("%0t: %0d expected replies never arrived", $time, exp_q.size());
			n_other_err++;
		end
		$display("errors: %0d value mismatches, %0d other failures", n_check_err, n_other_err);
		if (n_check_err == 0 && n_other_err == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+include
src/hsi_pkg.sv
src/hsi_clk_en_gen.sv
src/hsi_tx_ctrl.sv
src/hsi_rx_ctrl.sv
src/hsi_emergency_ctrl.sv
src/hsi_line_select.sv
src/hsi_master.sv
tb/hsi_master_sva.sv
tb/hsi_master_tb.sv

/* Bender.yml */
package:
  name: hsi_master

sources:
  - include_dirs:
      - include
    files:
      - src/hsi_pkg.sv
      - src/hsi_clk_en_gen.sv
      - src/hsi_tx_ctrl.sv
      - src/hsi_rx_ctrl.sv
      - src/hsi_emergency_ctrl.sv
      - src/hsi_line_select.sv
      - src/hsi_master.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/hsi_master_sva.sv
      - tb/hsi_master_tb.sv
